// ==== common/mem_op_pkg.sv ====
package mem_op_pkg;

    // memory opcode presented by the core, one per cycle
    typedef enum logic [3:0] {
        OP_NONE = 4'd0,
        OP_LB   = 4'd1,
        OP_LH   = 4'd2,
        OP_LW   = 4'd3,
        OP_LBU  = 4'd4,
        OP_LHU  = 4'd5,
        OP_SB   = 4'd6,
        OP_SH   = 4'd7,
        OP_SW   = 4'd8
    } mem_op_e;

    // width of a single access
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2
    } access_size_e;

endpackage

// ==== common/mem_cfg_pkg.sv ====
package mem_cfg_pkg;

    // data word and lane geometry
    localparam int DATA_W = 32;
    localparam int LANES = 4;
    localparam int LANE_W = DATA_W / LANES;

    // byte offset inside a word, address bits 1:0
    localparam int OFFSET_W = $clog2(LANES);

    // storage depth, index from address bits 13:2
    localparam int MEM_WORDS = 4096;
    localparam int INDEX_W = $clog2(MEM_WORDS);

endpackage

// ==== src/mem_access_decode.sv ====
module mem_access_decode (
    input  logic                      clk,
    input  logic                      reset,
    input  mem_op_pkg::mem_op_e       op,
    output logic                      store_en,
    output logic                      capture,
    output logic                      stall,
    output logic                      load_into_reg,
    output mem_op_pkg::access_size_e  size,
    output logic                      load_unsigned
);
    import mem_op_pkg::*;

    logic is_load;
    // set in the second cycle of a load, when load_data is presented
    logic load_valid;

    // opcode to access class, size and extension mode
    always_comb begin
        is_load = 1'b0;
        store_en = 1'b0;
        size = SIZE_WORD;
        load_unsigned = 1'b0;
        case (op)
            OP_LB: begin
                is_load = 1'b1;
                size = SIZE_BYTE;
            end
            OP_LH: begin
                is_load = 1'b1;
                size = SIZE_HALF;
            end
            OP_LW: begin
                is_load = 1'b1;
            end
            OP_LBU: begin
                is_load = 1'b1;
                size = SIZE_BYTE;
                load_unsigned = 1'b1;
            end
            OP_LHU: begin
                is_load = 1'b1;
                size = SIZE_HALF;
                load_unsigned = 1'b1;
            end
            OP_SB: begin
                store_en = 1'b1;
                size = SIZE_BYTE;
            end
            OP_SH: begin
                store_en = 1'b1;
                size = SIZE_HALF;
            end
            OP_SW: begin
                store_en = 1'b1;
            end
            default: begin
                is_load = 1'b0;
            end
        endcase
    end

    // first cycle of a load only; the core holds op while stalled
    assign capture = is_load && !load_valid;
    assign stall = capture;
    assign load_into_reg = is_load;

    // sets after the issue cycle, clears after the completion cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            load_valid <= 1'b0;
        end else begin
            load_valid <= capture;
        end
    end

endmodule

// ==== lane_array/store_lane_steer.sv ====
module store_lane_steer (
    input  logic                              store_en,
    input  mem_op_pkg::access_size_e          size,
    input  logic [mem_cfg_pkg::OFFSET_W-1:0]  byte_offset,
    input  logic [mem_cfg_pkg::DATA_W-1:0]    store_data,
    output logic [mem_cfg_pkg::LANES-1:0]     lane_we,
    output logic [mem_cfg_pkg::DATA_W-1:0]    lane_wdata
);
    import mem_op_pkg::*;
    import mem_cfg_pkg::*;

    localparam int HALF_LANES = LANES / 2;
    localparam int HALF_W = HALF_LANES * LANE_W;

    logic [LANE_W-1:0] low_byte;
    logic [HALF_W-1:0] low_half;

    assign low_byte = store_data[LANE_W-1:0];
    assign low_half = store_data[HALF_W-1:0];

    // data is replicated across lanes so each bank just takes its own slice,
    // the enables pick which lanes actually write
    always_comb begin
        lane_we = '0;
        lane_wdata = store_data;
        case (size)
            SIZE_BYTE: begin
                lane_wdata = {LANES{low_byte}};
                lane_we[byte_offset] = store_en;
            end
            SIZE_HALF: begin
                lane_wdata = {(LANES / HALF_LANES){low_half}};
                // offset bit 1 picks lanes 0-1 or 2-3
                lane_we[byte_offset[1] * HALF_LANES +: HALF_LANES] = {HALF_LANES{store_en}};
            end
            SIZE_WORD: begin
                lane_we = {LANES{store_en}};
            end
            default: begin
                lane_we = '0;
            end
        endcase
    end

endmodule

// ==== lane_array/byte_lane_bank.sv ====
module byte_lane_bank (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             we,
    input  logic [mem_cfg_pkg::INDEX_W-1:0]  index,
    input  logic [mem_cfg_pkg::LANE_W-1:0]   wdata,
    output logic [mem_cfg_pkg::LANE_W-1:0]   rdata
);
    import mem_cfg_pkg::*;

    // one byte per word of storage
    logic [LANE_W-1:0] mem [MEM_WORDS];

    always_ff @(posedge clk) begin
        if (reset) begin
            // whole bank is cleared on reset
            for (int i = 0; i < MEM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (we) begin
            mem[index] <= wdata;
        end
    end

    // combinational read, registered later by the aligner
    assign rdata = mem[index];

endmodule

// ==== lane_array/load_align_extend.sv ====
module load_align_extend (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              capture,
    input  mem_op_pkg::access_size_e          size,
    input  logic                              load_unsigned,
    input  logic [mem_cfg_pkg::OFFSET_W-1:0]  byte_offset,
    input  logic [mem_cfg_pkg::DATA_W-1:0]    lane_rdata,
    output logic [mem_cfg_pkg::DATA_W-1:0]    load_data
);
    import mem_op_pkg::*;
    import mem_cfg_pkg::*;

    localparam int HALF_W = 2 * LANE_W;

    logic [LANE_W-1:0] sel_byte;
    logic [HALF_W-1:0] sel_half;
    logic              byte_fill;
    logic              half_fill;
    logic [DATA_W-1:0] ext_value;

    // byte at the offset, half picked by offset bit 1
    assign sel_byte = lane_rdata[byte_offset * LANE_W +: LANE_W];
    assign sel_half = lane_rdata[byte_offset[1] * HALF_W +: HALF_W];

    // fill bit for the upper part, zero for LBU/LHU
    assign byte_fill = sel_byte[LANE_W-1] & ~load_unsigned;
    assign half_fill = sel_half[HALF_W-1] & ~load_unsigned;

    always_comb begin
        case (size)
            SIZE_BYTE: begin
                ext_value = {{(DATA_W - LANE_W){byte_fill}}, sel_byte};
            end
            SIZE_HALF: begin
                ext_value = {{(DATA_W - HALF_W){half_fill}}, sel_half};
            end
            SIZE_WORD: begin
                ext_value = lane_rdata;
            end
            default: begin
                ext_value = '0;
            end
        endcase
    end

    // result is valid only for the cycle after capture, zero otherwise
    always_ff @(posedge clk) begin
        if (reset) begin
            load_data <= '0;
        end else if (capture) begin
            load_data <= ext_value;
        end else begin
            load_data <= '0;
        end
    end

endmodule

// ==== src/data_mem_top.sv ====
module data_mem_top (
    input  logic                            clk,
    input  logic                            reset,
    input  mem_op_pkg::mem_op_e             op,
    input  logic [mem_cfg_pkg::DATA_W-1:0]  address,
    input  logic [mem_cfg_pkg::DATA_W-1:0]  store_data,
    output logic [mem_cfg_pkg::DATA_W-1:0]  load_data,
    output logic                            stall,
    output logic                            load_into_reg
);
    import mem_op_pkg::*;
    import mem_cfg_pkg::*;

    // decoder outputs
    logic         store_en;
    logic         capture;
    logic         load_unsigned;
    access_size_e size;

    // address split, bits above the index are ignored
    logic [OFFSET_W-1:0] byte_offset;
    logic [INDEX_W-1:0]  word_index;

    // lane buses
    logic [LANES-1:0]  lane_we;
    logic [DATA_W-1:0] lane_wdata;
    logic [DATA_W-1:0] lane_rdata;

    assign byte_offset = address[OFFSET_W-1:0];
    assign word_index = address[OFFSET_W +: INDEX_W];

    mem_access_decode u_decode (
        .clk           (clk),
        .reset         (reset),
        .op            (op),
        .store_en      (store_en),
        .capture       (capture),
        .stall         (stall),
        .load_into_reg (load_into_reg),
        .size          (size),
        .load_unsigned (load_unsigned)
    );

    store_lane_steer u_steer (
        .store_en    (store_en),
        .size        (size),
        .byte_offset (byte_offset),
        .store_data  (store_data),
        .lane_we     (lane_we),
        .lane_wdata  (lane_wdata)
    );

    // one bank per byte lane, all indexed by the same word
    generate
        for (genvar lane = 0; lane < LANES; lane++) begin : g_lane
            byte_lane_bank u_bank (
                .clk   (clk),
                .reset (reset),
                .we    (lane_we[lane]),
                .index (word_index),
                .wdata (lane_wdata[lane * LANE_W +: LANE_W]),
                .rdata (lane_rdata[lane * LANE_W +: LANE_W])
            );
        end
    endgenerate

    load_align_extend u_align (
        .clk           (clk),
        .reset         (reset),
        .capture       (capture),
        .size          (size),
        .load_unsigned (load_unsigned),
        .byte_offset   (byte_offset),
        .lane_rdata    (lane_rdata),
        .load_data     (load_data)
    );

endmodule

// ==== verif/mem_model.svh ====
`ifndef MEM_MODEL_SVH
`define MEM_MODEL_SVH

// byte image of the 16 KB address space, higher address bits wrap
logic [7:0] shadow [0:16383];

function automatic void shadow_clear();
    for (int i = 0; i < 16384; i++) begin
        shadow[i] = 8'h00;
    end
endfunction

function automatic bit is_load_op(input mem_op_e o);
    return o inside {OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU};
endfunction

// store merge: byte at the offset, half at offset bit 1, word ignores the offset
function automatic void model_store(input mem_op_e o, input logic [31:0] addr,
                                    input logic [31:0] data);
    case (o)
        OP_SB: begin
            shadow[addr[13:0]] = data[7:0];
        end
        OP_SH: begin
            shadow[{addr[13:2], addr[1], 1'b0}] = data[7:0];
            shadow[{addr[13:2], addr[1], 1'b1}] = data[15:8];
        end
        OP_SW: begin
            for (int i = 0; i < 4; i++) begin
                shadow[{addr[13:2], i[1:0]}] = data[i * 8 +: 8];
            end
        end
        default: begin
        end
    endcase
endfunction

// load value after alignment and sign or zero extension
function automatic logic [31:0] model_load(input mem_op_e o, input logic [31:0] addr);
    logic [7:0]  b;
    logic [15:0] h;
    logic [31:0] w;
    b = shadow[addr[13:0]];
    h = {shadow[{addr[13:2], addr[1], 1'b1}], shadow[{addr[13:2], addr[1], 1'b0}]};
    w = {shadow[{addr[13:2], 2'd3}], shadow[{addr[13:2], 2'd2}],
         shadow[{addr[13:2], 2'd1}], shadow[{addr[13:2], 2'd0}]};
    case (o)
        OP_LB:   return {{24{b[7]}}, b};
        OP_LBU:  return {24'h000000, b};
        OP_LH:   return {{16{h[15]}}, h};
        OP_LHU:  return {16'h0000, h};
        OP_LW:   return w;
        default: return 32'h00000000;
    endcase
endfunction

`endif

// ==== verif/data_mem_tb.sv ====
module data_mem_tb;
    import mem_op_pkg::*;

    `include "mem_model.svh"

    logic        clk;
    logic        reset;
    mem_op_e     op;
    logic [31:0] address;
    logic [31:0] store_data;
    logic [31:0] load_data;
    logic        stall;
    logic        load_into_reg;
    integer      seed;

    // observed and expected values waiting for the compare process
    string       name_q[$];
    logic [31:0] act_q[$];
    logic [31:0] exp_q[$];

    data_mem_top u_data_mem_top (
        .clk           (clk),
        .reset         (reset),
        .op            (op),
        .address       (address),
        .store_data    (store_data),
        .load_data     (load_data),
        .stall         (stall),
        .load_into_reg (load_into_reg)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("CHECKS FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("ERR %s actual=0x%08h expected=0x%08h", name, actual, expected);
            $display("CHECKS FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic expect_value(input string name, input logic [31:0] actual,
                                input logic [31:0] expected);
        name_q.push_back(name);
        act_q.push_back(actual);
        exp_q.push_back(expected);
    endtask

    initial begin : compare_proc
        string       nm;
        logic [31:0] act;
        logic [31:0] exp;
        forever begin
            @(posedge clk);
            while (act_q.size() > 0) begin
                nm = name_q.pop_front();
                act = act_q.pop_front();
                exp = exp_q.pop_front();
                check_value(nm, act, exp);
            end
        end
    end

    function automatic mem_op_e pick_op(input logic [2:0] sel);
        case (sel)
            3'd0:    return OP_LB;
            3'd1:    return OP_LH;
            3'd2:    return OP_LW;
            3'd3:    return OP_LBU;
            3'd4:    return OP_LHU;
            3'd5:    return OP_SB;
            3'd6:    return OP_SH;
            default: return OP_SW;
        endcase
    endfunction

    // entered and left 2 time units after a rising edge
    task automatic issue_op(input mem_op_e o, input logic [31:0] addr,
                            input logic [31:0] data, output logic [31:0] result);
        logic [31:0] expected;
        int          waited;
        op = o;
        address = addr;
        store_data = data;
        result = 32'h0;
        @(negedge clk);
        if (is_load_op(o)) begin
            expected = model_load(o, addr);
            expect_value("stall", 32'(stall), 32'd1);
            expect_value("load_into_reg", 32'(load_into_reg), 32'd1);
            waited = 0;
            do begin
                @(negedge clk);
                // a load completes in the cycle right after issue
                if (waited == 0) begin
                    expect_value("stall", 32'(stall), 32'd0);
                end
                waited++;
            end while (stall && waited < 10);
            if (stall) begin
                abort_run("timeout: stall stayed high for 10 cycles after a load");
            end else begin
                expect_value("load_data", load_data, expected);
                expect_value("load_into_reg", 32'(load_into_reg), 32'd1);
                result = load_data;
            end
        end else begin
            // a store never stalls
            expect_value("stall", 32'(stall), 32'd0);
            expect_value("load_into_reg", 32'(load_into_reg), 32'd0);
            model_store(o, addr, data);
        end
        @(posedge clk);
        #2;
    endtask

    task automatic idle_cycle();
        op = OP_NONE;
        @(negedge clk);
        expect_value("stall", 32'(stall), 32'd0);
        expect_value("load_into_reg", 32'(load_into_reg), 32'd0);
        expect_value("load_data", load_data, 32'd0);
        @(posedge clk);
        #2;
    endtask

    initial begin : main_flow
        logic [31:0] rd;
        logic [31:0] r;
        logic [31:0] sel;
        logic [31:0] addr;
        int          drained;
        seed = 32'h8a477783;
        reset = 1'b1;
        op = OP_NONE;
        address = 32'h0;
        store_data = 32'h0;
        shadow_clear();
        repeat (4) @(posedge clk);
        #2;
        reset = 1'b0;

        // memory reads as zero after reset
        idle_cycle();
        issue_op(OP_LW, 32'h0000_0000, 32'h0, rd);
        issue_op(OP_LW, 32'h0000_0104, 32'h0, rd);
        issue_op(OP_LW, 32'h0000_3ffc, 32'h0, rd);
        idle_cycle();

        // word stores, neighbours untouched, upper address bits wrap
        issue_op(OP_SW, 32'h0000_0040, 32'h1234_5678, rd);
        issue_op(OP_SW, 32'h0000_0044, 32'hdead_beef, rd);
        issue_op(OP_LW, 32'h0000_0040, 32'h0, rd);
        issue_op(OP_LW, 32'h0000_0044, 32'h0, rd);
        issue_op(OP_LW, 32'h0000_0048, 32'h0, rd);
        issue_op(OP_SW, 32'h4000_0043, 32'h0f0e_0d0c, rd);
        issue_op(OP_LW, 32'h0000_0040, 32'h0, rd);
        idle_cycle();

        // byte and half merges into existing words
        issue_op(OP_SW, 32'h0000_0080, 32'ha1b2_c3d4, rd);
        for (int k = 0; k < 4; k++) begin
            issue_op(OP_SB, 32'h0000_0080 + 32'(k), 32'hffff_ff11 + 32'(k * 17), rd);
            issue_op(OP_LW, 32'h0000_0080, 32'h0, rd);
        end
        issue_op(OP_SW, 32'h0000_0084, 32'h0bad_f00d, rd);
        issue_op(OP_SH, 32'h0000_0084, 32'h1234_beef, rd);
        issue_op(OP_LW, 32'h0000_0084, 32'h0, rd);
        issue_op(OP_SH, 32'h0000_0087, 32'h0000_cafe, rd);
        issue_op(OP_LW, 32'h0000_0084, 32'h0, rd);
        idle_cycle();

        // sign and zero extension
        issue_op(OP_SW, 32'h0000_00c0, 32'h80ff_7f80, rd);
        for (int k = 0; k < 4; k++) begin
            issue_op(OP_LB, 32'h0000_00c0 + 32'(k), 32'h0, rd);
            issue_op(OP_LBU, 32'h0000_00c0 + 32'(k), 32'h0, rd);
        end
        issue_op(OP_LB, 32'h0000_00c0, 32'h0, rd);
        expect_value("load_data", rd, 32'hffff_ff80);
        issue_op(OP_LH, 32'h0000_00c0, 32'h0, rd);
        issue_op(OP_LH, 32'h0000_00c2, 32'h0, rd);
        issue_op(OP_LHU, 32'h0000_00c2, 32'h0, rd);
        expect_value("load_data", rd, 32'h0000_80ff);
        idle_cycle();

        // random mix over a 64-byte window with random upper bits
        for (int i = 0; i < 300; i++) begin
            r = $random(seed);
            sel = $random(seed);
            addr = 32'h0000_0100 + (r & 32'h0000_003f);
            addr[31:14] = r[31:14];
            issue_op(pick_op(sel[2:0]), addr, $random(seed), rd);
            if (sel[5:3] == 3'd0) begin
                idle_cycle();
            end
        end
        for (int w = 0; w < 16; w++) begin
            issue_op(OP_LW, 32'h0000_0100 + 32'(w * 4), 32'h0, rd);
        end
        idle_cycle();

        drained = 0;
        while (act_q.size() > 0 && drained < 5) begin
            @(posedge clk);
            drained++;
        end
        if (act_q.size() > 0) begin
            abort_run("compare queue did not drain before the end of the run");
        end else begin
            $display("ALL CHECKS PASSED");
            $finish;
        end
    end

endmodule

// ==== sim.f ====
+incdir+verif
common/mem_op_pkg.sv
common/mem_cfg_pkg.sv
src/mem_access_decode.sv
lane_array/store_lane_steer.sv
lane_array/byte_lane_bank.sv
lane_array/load_align_extend.sv
src/data_mem_top.sv
verif/data_mem_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the data memory testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -f sim.f --top-module data_mem_tb -o data_mem_sim \
    || { echo "build failed"; exit 1; }
./obj_dir/data_mem_sim > sim.log 2>&1
cat sim.log
grep -q "ALL CHECKS PASSED" sim.log && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
